// ==== bootLoader.f ====
+incdir+include
+incdir+tb
rtl/bootLoaderPkg.sv
rtl/bootWordAssembler.sv
rtl/bootIowdParser.sv
rtl/bootMemory.sv
rtl/bootLoader.sv
tb/bootLoader_tb.sv

// ==== include/bootLoader_defines.svh ====
`ifndef BOOT_LOADER_DEFINES_SVH
`define BOOT_LOADER_DEFINES_SVH

//////////////////////////////////////////////////
// KL10 word geometry
//////////////////////////////////////////////////

// Full machine word, bit 35 is the leftmost bit
`define BOOT_WORD_BITS 36

// One half word
// The left half holds the IOWD count, the right half the address
`define BOOT_HALF_BITS 18

//////////////////////////////////////////////////
// Front-end executable file format
//////////////////////////////////////////////////

// Bytes per word in the file
// Bytes 0..3 are full, byte 4 carries only four bits in its high nibble
`define BOOT_BYTES_PER_WORD 5

//////////////////////////////////////////////////
// Boot memory
//////////////////////////////////////////////////

// Address bits actually decoded by the boot memory
// Higher address bits wrap, so the memory repeats every 1024 words
`define BOOT_MEM_ADDR_BITS 10

`endif

// ==== rtl/bootIowdParser.sv ====
`timescale 1ns/100ps
`include "bootLoader_defines.svh"

// Interprets the word stream as IOWD blocks and a start word
module bootIowdParser (
  input  logic                      CLK,
  input  logic                      arstN,
  input  logic                      loadStart,
  input  bootLoaderPkg::tWord       wordIn,
  input  logic                      wordValid,
  output bootLoaderPkg::tMemWrite   memWrite,
  output logic                      memWriteEn,
  output bootLoaderPkg::tLoadStatus status
);
  import bootLoaderPkg::*;

  // Expecting a header or start word, or inside a data block
  typedef enum logic {
    stHeader,
    stData
  } tParseState;

  tParseState state;
  // Data words still due in the current block
  tHalf       remaining;
  // Address of the next data word
  tHalf       nextAddr;
  logic       loading;
  logic       loadDone;
  tWord       startWord;
  tExtent     extent;
  tHalf       wordCount;

  logic       acceptWord;
  logic       negLeft;
  logic       isHeader;
  logic       isStart;
  logic       isData;

  //////////////////////////////////////////////////
  // Word classification
  //////////////////////////////////////////////////

  // Words outside a load are dropped
  assign acceptWord = wordValid && loading;

  // Left half of 400000 octal or more, i.e. a negative count
  assign negLeft = wordIn.lh[`BOOT_HALF_BITS-1];

  assign isHeader = acceptWord && (state == stHeader) && negLeft;
  // Positive left half in place of a header ends the load
  assign isStart  = acceptWord && (state == stHeader) && !negLeft;
  assign isData   = acceptWord && (state == stData);

  //////////////////////////////////////////////////
  // Block sequencing and statistics
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      state            <= stHeader;
      remaining        <= '0;
      nextAddr         <= '0;
      loading          <= 1'b0;
      loadDone         <= 1'b0;
      extent.minAddr   <= '1;
      extent.maxAddr   <= '0;
      wordCount        <= '0;
      memWriteEn       <= 1'b0;
    end else if (loadStart) begin
      // Fresh image, forget everything from the last one
      state            <= stHeader;
      remaining        <= '0;
      loading          <= 1'b1;
      loadDone         <= 1'b0;
      extent.minAddr   <= '1;
      extent.maxAddr   <= '0;
      wordCount        <= '0;
      memWriteEn       <= 1'b0;
    end else begin
      // Write strobe trails the data word by one cycle
      memWriteEn <= isData;

      if (isHeader) begin
        // Count is 1000000 octal minus the left half, modulo 2^18
        remaining <= tHalf'(0) - wordIn.lh;
        nextAddr  <= wordIn.rh;
        state     <= stData;
      end

      if (isData) begin
        nextAddr  <= nextAddr + 1'b1;
        remaining <= remaining - 1'b1;
        wordCount <= wordCount + 1'b1;
        // Extents use the full 18 bit address
        if (nextAddr < extent.minAddr) begin
          extent.minAddr <= nextAddr;
        end
        if (nextAddr > extent.maxAddr) begin
          extent.maxAddr <= nextAddr;
        end
        // Last word of the block, back to header decode
        if (remaining == tHalf'(1)) begin
          state <= stHeader;
        end
      end

      if (isStart) begin
        loading  <= 1'b0;
        loadDone <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Payload capture
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (isData) begin
      memWrite.addr <= nextAddr;
      memWrite.data <= wordIn;
    end
    if (isStart) begin
      startWord <= wordIn;
    end
  end

  // Status as seen by the host
  assign status.loading   = loading;
  assign status.loadDone  = loadDone;
  assign status.startWord = startWord;
  assign status.extent    = extent;
  assign status.wordCount = wordCount;

endmodule

// ==== rtl/bootLoader.sv ====
`timescale 1ns/100ps
`include "bootLoader_defines.svh"

// KL10 bootstrap loader
// Byte stream in, words into boot memory, status out
module bootLoader (
  input  logic                      CLK,
  input  logic                      arstN,
  // One cycle pulse to begin a new image
  input  logic                      loadStart,
  // File bytes, at most one per cycle
  input  logic [7:0]                byteIn,
  input  logic                      byteValid,
  // Readback of the loaded image
  input  bootLoaderPkg::tHalf       readAddr,
  output bootLoaderPkg::tWord       readData,
  output bootLoaderPkg::tLoadStatus status
);
  import bootLoaderPkg::*;

  // Assembler to parser
  tWord     word;
  logic     wordValid;

  // Parser to memory
  tMemWrite memWrite;
  logic     memWriteEn;

  //////////////////////////////////////////////////
  // Stage 1, bytes to words
  //////////////////////////////////////////////////

  bootWordAssembler wordAssembler_inst (
    .CLK       (CLK),
    .arstN     (arstN),
    .loadStart (loadStart),
    .byteIn    (byteIn),
    .byteValid (byteValid),
    .wordOut   (word),
    .wordValid (wordValid)
  );

  //////////////////////////////////////////////////
  // Stage 2, IOWD decode
  //////////////////////////////////////////////////

  bootIowdParser iowdParser_inst (
    .CLK        (CLK),
    .arstN      (arstN),
    .loadStart  (loadStart),
    .wordIn     (word),
    .wordValid  (wordValid),
    .memWrite   (memWrite),
    .memWriteEn (memWriteEn),
    .status     (status)
  );

  //////////////////////////////////////////////////
  // Stage 3, boot memory
  //////////////////////////////////////////////////

  bootMemory #(
    .AddrBits (`BOOT_MEM_ADDR_BITS)
  ) memory_inst (
    .CLK        (CLK),
    .memWrite   (memWrite),
    .memWriteEn (memWriteEn),
    .readAddr   (readAddr),
    .readData   (readData)
  );

endmodule

// ==== rtl/bootLoaderPkg.sv ====
`include "bootLoader_defines.svh"

package bootLoaderPkg;

  //////////////////////////////////////////////////
  // Words
  //////////////////////////////////////////////////

  // One 18 bit half word
  typedef logic [`BOOT_HALF_BITS-1:0] tHalf;

  // One 36 bit word
  // Left half is the upper 18 bits, as on the KL10
  typedef struct packed {
    tHalf lh;
    tHalf rh;
  } tWord;

  //////////////////////////////////////////////////
  // Memory write request
  //////////////////////////////////////////////////

  // Full 18 bit address, the memory decodes only its low bits
  typedef struct packed {
    tHalf addr;
    tWord data;
  } tMemWrite;

  //////////////////////////////////////////////////
  // Load status
  //////////////////////////////////////////////////

  // Lowest and highest addresses written in this load
  typedef struct packed {
    tHalf minAddr;
    tHalf maxAddr;
  } tExtent;

  // Everything the loader reports about the current image
  typedef struct packed {
    // Set by loadStart, cleared by the start word
    logic   loading;
    // Held high from the start word to the next loadStart
    logic   loadDone;
    // Start instruction that ended the load
    tWord   startWord;
    tExtent extent;
    // Number of data words written
    tHalf   wordCount;
  } tLoadStatus;

endpackage

// ==== rtl/bootMemory.sv ====
`timescale 1ns/100ps
`include "bootLoader_defines.svh"

// Boot image store
// One write port from the parser, one registered read port
module bootMemory #(
  parameter int AddrBits = `BOOT_MEM_ADDR_BITS
) (
  input  logic                    CLK,
  input  bootLoaderPkg::tMemWrite memWrite,
  input  logic                    memWriteEn,
  input  bootLoaderPkg::tHalf     readAddr,
  output bootLoaderPkg::tWord     readData
);
  import bootLoaderPkg::*;

  localparam int Depth = 1 << AddrBits;

  tWord                mem [Depth];
  logic [AddrBits-1:0] writeIndex;
  logic [AddrBits-1:0] readIndex;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Only the low address bits are decoded
  // Images above the memory size wrap around
  assign writeIndex = memWrite.addr[AddrBits-1:0];
  assign readIndex  = readAddr[AddrBits-1:0];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (memWriteEn) begin
      mem[writeIndex] <= memWrite.data;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Registered read, data one cycle after the address
  // A read of the word being written returns the old contents
  always_ff @(posedge CLK) begin
    readData <= mem[readIndex];
  end

endmodule

// ==== rtl/bootWordAssembler.sv ====
`timescale 1ns/100ps
`include "bootLoader_defines.svh"

// Packs five file bytes into one 36 bit word
module bootWordAssembler (
  input  logic                CLK,
  input  logic                arstN,
  input  logic                loadStart,
  input  logic [7:0]          byteIn,
  input  logic                byteValid,
  output bootLoaderPkg::tWord wordOut,
  output logic                wordValid
);
  import bootLoaderPkg::*;

  // Phase counts 0..4 within one file word
  localparam int PhaseBits = $clog2(`BOOT_BYTES_PER_WORD);
  localparam int LastPhase = `BOOT_BYTES_PER_WORD - 1;
  // Bits delivered by the four full bytes
  localparam int HeadBits  = `BOOT_WORD_BITS - 4;

  logic [PhaseBits-1:0] phase;
  logic                 lastByte;
  // Bytes 0..3, oldest byte ends up in the top slot
  logic [HeadBits-1:0]  headBytes;

  // Current byte is byte 4 of the word
  assign lastByte = (phase == PhaseBits'(LastPhase));

  //////////////////////////////////////////////////
  // Byte phase and word strobe
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      phase     <= '0;
      wordValid <= 1'b0;
    end else if (loadStart) begin
      // New image starts on a word boundary
      phase     <= '0;
      wordValid <= 1'b0;
    end else begin
      // One cycle pulse after the fifth byte is captured
      wordValid <= byteValid && lastByte;
      if (byteValid) begin
        if (lastByte) begin
          phase <= '0;
        end else begin
          phase <= phase + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Byte packing
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Full bytes shift in from the right
    if (byteValid && !lastByte) begin
      headBytes <= {headBytes[HeadBits-9:0], byteIn};
    end
    // Byte 4 supplies the low four bits from its high nibble
    // Its low nibble is padding in the file format and is dropped
    if (byteValid && lastByte) begin
      wordOut <= tWord'({headBytes, byteIn[7:4]});
    end
  end

endmodule

// ==== tb/bootLoaderTable.svh ====
`ifndef BOOT_LOADER_TABLE_SVH
`define BOOT_LOADER_TABLE_SVH

// Image table
// tableWords holds all images back to back, in octal, LH then RH
// Per image: first word, words up to the start word, tail words sent
// after loadDone, then expected startWord, minAddr, maxAddr, wordCount

localparam int NumImages     = 4;
localparam int NumTableWords = 31;

//////////////////////////////////////////////////
// Word stream
//////////////////////////////////////////////////

logic [`BOOT_WORD_BITS-1:0] tableWords [NumTableWords] = '{
  // Image 0, one block of 4 at 100
  36'o777774000100,
  36'o123456701234,
  36'o765432107654,
  36'o000001000017,
  36'o777777777777,
  36'o254000001000,
  // Image 1, blocks at 500, 200, 50 in falling order
  36'o777776000500,
  36'o111111111111,
  36'o222222222222,
  36'o777775000200,
  36'o333333333333,
  36'o444444444444,
  36'o555555555555,
  36'o777777000050,
  36'o666666666666,
  36'o254000000200,
  // Image 2, above 1024 and across the 1024 boundary
  36'o777775003000,
  36'o700000000001,
  36'o700000000002,
  36'o700000000003,
  36'o777775001777,
  36'o710000000004,
  36'o710000000005,
  36'o710000000006,
  36'o254000003000,
  // Tail after the start word, must not land in memory
  36'o777777001777,
  36'o000000000000,
  // Image 3, small block after a busy image
  36'o777776000040,
  36'o040404040404,
  36'o050505050505,
  36'o254000000040
};

//////////////////////////////////////////////////
// Per image layout and expected status
//////////////////////////////////////////////////

int imageFirst  [NumImages] = '{0, 6, 16, 27};
int imageLength [NumImages] = '{6, 10, 9, 4};
int imageTail   [NumImages] = '{0, 0, 2, 0};

logic [`BOOT_WORD_BITS-1:0] expStart [NumImages] = '{
  36'o254000001000,
  36'o254000000200,
  36'o254000003000,
  36'o254000000040
};

logic [`BOOT_HALF_BITS-1:0] expMin   [NumImages] = '{18'o100, 18'o050, 18'o1777, 18'o040};
logic [`BOOT_HALF_BITS-1:0] expMax   [NumImages] = '{18'o103, 18'o501, 18'o3002, 18'o041};
logic [`BOOT_HALF_BITS-1:0] expCount [NumImages] = '{18'd4, 18'd6, 18'd6, 18'd2};

string imageName [NumImages] = '{
  "single block",
  "falling block addresses",
  "address wrap and late words",
  "reload after loadStart"
};

`endif

// ==== tb/bootLoader_tb.sv ====
`timescale 1ns/100ps
`include "bootLoader_defines.svh"

module bootLoader_tb;
  import bootLoaderPkg::*;

  `include "bootLoaderTable.svh"

  // Cycles allowed for loadDone after the last byte
  localparam int WaitLimit = 400;
  localparam int AddrMask  = (1 << `BOOT_MEM_ADDR_BITS) - 1;

  logic       CLK;
  logic       arstN;
  logic       loadStart;
  logic [7:0] byteIn;
  logic       byteValid;
  tHalf       readAddr;
  tWord       readData;
  tLoadStatus status;

  integer seed;
  int     testErrors;
  int     totalErrors;
  int     testsPassed;
  int     testsFailed;
  int     currentTest;
  bit     timedOut;

  bootLoader bootLoader_inst (
    .CLK       (CLK),
    .arstN     (arstN),
    .loadStart (loadStart),
    .byteIn    (byteIn),
    .byteValid (byteValid),
    .readAddr  (readAddr),
    .readData  (readData),
    .status    (status)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One byte strobe, then 0..3 idle cycles
  task automatic sendByte(input logic [7:0] value);
    int gap;
    gap = $unsigned($random(seed)) % 4;
    @(posedge CLK);
    byteIn    <= value;
    byteValid <= 1'b1;
    repeat (gap) begin
      @(posedge CLK);
      byteValid <= 1'b0;
    end
  endtask

  // File format, four full bytes then the low 4 bits in a high nibble
  task automatic sendWord(input logic [35:0] value);
    logic [3:0] pad;
    pad = 4'($random(seed));
    sendByte(value[35:28]);
    sendByte(value[27:20]);
    sendByte(value[19:12]);
    sendByte(value[11:4]);
    // Low nibble is junk and should be dropped
    sendByte({value[3:0], pad});
  endtask

  task automatic dropByteValid();
    @(posedge CLK);
    byteValid <= 1'b0;
  endtask

  task automatic pulseLoadStart();
    @(posedge CLK);
    loadStart <= 1'b1;
    @(posedge CLK);
    loadStart <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic compareField(input string name, input logic [35:0] got,
                              input logic [35:0] expected);
    if (got !== expected) begin
      $display("Error: test %0d %s got 0x%09h expected 0x%09h",
               currentTest, name, got, expected);
      testErrors++;
    end
  endtask

  task automatic waitLoadDone(output bit done);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!status.loadDone && cycles < WaitLimit) begin
      @(negedge CLK);
      cycles++;
    end
    done = status.loadDone;
  endtask

  // Registered read, data one cycle after the address
  task automatic readBackWord(input tHalf addr, input logic [35:0] expected);
    @(posedge CLK);
    readAddr <= addr;
    @(posedge CLK);
    @(negedge CLK);
    compareField($sformatf("readData[0x%05h]", addr), readData, expected);
  endtask

  // Walk the IOWD headers and read every data word back
  task automatic readBackImage(input int img);
    int          w;
    int          last;
    int          blockLen;
    int          i;
    tHalf        addr;
    logic [35:0] hdr;
    bit          inBlocks;
    w        = imageFirst[img];
    last     = w + imageLength[img] - 1;
    inBlocks = 1'b1;
    while (inBlocks && w < last) begin
      hdr = tableWords[w];
      if (hdr[35]) begin
        // Count is 1000000 octal minus the left half
        blockLen = 'o1000000 - int'(hdr[35:18]);
        addr     = hdr[17:0];
        for (i = 0; i < blockLen; i++) begin
          // Memory repeats every 1024 words
          readBackWord(tHalf'((addr + i) & AddrMask), tableWords[w + 1 + i]);
        end
        w = w + 1 + blockLen;
      end else begin
        inBlocks = 1'b0;
      end
    end
  endtask

  task automatic checkStatus(input int img);
    compareField("loading", 36'(status.loading), 36'h0);
    compareField("loadDone", 36'(status.loadDone), 36'h1);
    compareField("startWord", status.startWord, expStart[img]);
    compareField("minAddr", 36'(status.extent.minAddr), 36'(expMin[img]));
    compareField("maxAddr", 36'(status.extent.maxAddr), 36'(expMax[img]));
    compareField("wordCount", 36'(status.wordCount), 36'(expCount[img]));
  endtask

  task automatic runImage(input int img);
    int w;
    int first;
    int stop;
    bit done;
    first = imageFirst[img];
    stop  = first + imageLength[img];
    pulseLoadStart();
    // Status must be clear right after loadStart
    @(negedge CLK);
    compareField("loading", 36'(status.loading), 36'h1);
    compareField("loadDone", 36'(status.loadDone), 36'h0);
    compareField("wordCount", 36'(status.wordCount), 36'h0);
    compareField("minAddr", 36'(status.extent.minAddr), 36'h3ffff);
    compareField("maxAddr", 36'(status.extent.maxAddr), 36'h0);
    for (w = first; w < stop; w++) begin
      sendWord(tableWords[w]);
    end
    dropByteValid();
    waitLoadDone(done);
    if (!done) begin
      $display("Test %0d: loadDone never came after the start word", currentTest);
      testErrors++;
      timedOut = 1'b1;
    end else begin
      // Words after the start word
      for (w = stop; w < stop + imageTail[img]; w++) begin
        sendWord(tableWords[w]);
      end
      dropByteValid();
      // Write path is two cycles deep, one spare
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      checkStatus(img);
      readBackImage(img);
    end
  endtask

  task automatic reportTest(input string name);
    if (testErrors == 0) begin
      $display("Test %0d %s: passed", currentTest, name);
      testsPassed++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", currentTest, name, testErrors);
      testsFailed++;
    end
    totalErrors += testErrors;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int img;
    CLK         = 1'b0;
    arstN       = 1'b0;
    loadStart   = 1'b0;
    byteIn      = 8'h00;
    byteValid   = 1'b0;
    readAddr    = '0;
    seed        = 19958;
    totalErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    timedOut    = 1'b0;

    repeat (4) @(posedge CLK);
    arstN <= 1'b1;
    @(negedge CLK);

    // Reset values
    currentTest = 0;
    testErrors  = 0;
    compareField("loading", 36'(status.loading), 36'h0);
    compareField("loadDone", 36'(status.loadDone), 36'h0);
    compareField("wordCount", 36'(status.wordCount), 36'h0);
    compareField("minAddr", 36'(status.extent.minAddr), 36'h3ffff);
    compareField("maxAddr", 36'(status.extent.maxAddr), 36'h0);
    reportTest("reset values");

    for (img = 0; img < NumImages && !timedOut; img++) begin
      currentTest = img + 1;
      testErrors  = 0;
      runImage(img);
      reportTest(imageName[img]);
    end

    $display("Tests passed %0d, failed %0d, errors %0d",
             testsPassed, testsFailed, totalErrors);
    if (totalErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
